//--- Makefile
VERILATOR ?= verilator
TOP ?= garbler_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/garble_sequencer.sv
module garble_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic credit_return,
	input gc_pkg::wire_id_t n_inputs,
	input logic [gc_pkg::GATE_W-1:0] n_gates,
	input gc_pkg::gate_t gate,
	input gc_pkg::label_t label0,
	input gc_pkg::label_t label1,
	output logic [gc_pkg::GATE_W-1:0] gate_index,
	output logic take0,
	output logic take1,
	output logic busy,
	output gc_pkg::msg_tag_t tag,
	output gc_pkg::wire_id_t index0,
	output gc_pkg::wire_id_t index1,
	output gc_pkg::label_t data0,
	output gc_pkg::label_t data1,
	label_port_if.master labels
);
	import gc_pkg::*;

	typedef enum logic [2:0] {IDLE, KEYS, CONSTS, GARBLE, MASKS} state_t;

	state_t state;
	state_t next_state;
	logic [GATE_W-1:0] gate_cnt;
	logic [$clog2(MAX_OUTPUTS)-1:0] out_cnt;
	logic [MAX_OUTPUTS-1:0] mask;
	logic [CREDIT_W-1:0] credits;
	label_t r_offset;
	label_t r_next;
	label_t result;
	wire_id_t input_limit;
	wire_id_t out_wire;
	logic start_run;
	logic credit_ok;
	logic need0;
	logic need1;
	logic gate_done;
	logic last_gate;

	assign start_run = (state == IDLE) && start;
	assign credit_ok = (credits != '0);
	assign busy = (state != IDLE);
	assign gate_index = gate_cnt;
	assign r_next = {label0[LABEL_W-1:1], 1'b1};

	// operand lookup straight from the current gate
	assign labels.rd_addr0 = gate.in0;
	assign labels.rd_addr1 = gate.in1;
	assign labels.clear = start_run;

	assign input_limit = n_inputs + WIRE_INPUT_BASE;
	assign out_wire = n_inputs + WIRE_INPUT_BASE + wire_id_t'(gate_cnt);
	assign last_gate = (gate_cnt == n_gates - GATE_W'(1));

	// inputs get a fresh label on first use; a repeated operand is fetched once
	assign need0 = (gate.in0 < input_limit) && !labels.rd_defined0;
	assign need1 = (gate.in1 < input_limit) && !labels.rd_defined1
		&& (gate.op != GATE_NOT) && !(need0 && gate.in1 == gate.in0);

	// free-XOR evaluation
	always_comb begin
		case (gate.op)
			GATE_XNOR: result = labels.rd_label0 ^ labels.rd_label1 ^ r_offset;
			GATE_NOT: result = labels.rd_label0 ^ r_offset;
			default: result = labels.rd_label0 ^ labels.rd_label1;
		endcase
	end

	always_comb begin
		next_state = state;
		take0 = 1'b0;
		take1 = 1'b0;
		gate_done = 1'b0;
		labels.wr_en0 = 1'b0;
		labels.wr_en1 = 1'b0;
		labels.wr_addr0 = gate.in0;
		labels.wr_addr1 = gate.in1;
		labels.wr_label0 = label0;
		labels.wr_label1 = label1;
		tag = TAG_NONE;
		index0 = '1;
		index1 = '1;
		data0 = '0;
		data1 = '0;
		case (state)
			IDLE: begin
				if (start) begin
					next_state = KEYS;
				end
			end
			KEYS: begin
				if (credit_ok) begin
					take0 = 1'b1;
					take1 = 1'b1;
					tag = TAG_KEYS;
					data0 = r_next;
					data1 = label1;
					next_state = CONSTS;
				end
			end
			CONSTS: begin
				if (credit_ok) begin
					take0 = 1'b1;
					take1 = 1'b1;
					labels.wr_en0 = 1'b1;
					labels.wr_en1 = 1'b1;
					labels.wr_addr0 = WIRE_CONST0;
					labels.wr_addr1 = WIRE_CONST1;
					tag = TAG_INPUT_BOTH;
					index0 = WIRE_CONST0;
					index1 = WIRE_CONST1;
					data0 = label0;
					data1 = label1;
					next_state = (n_gates == '0) ? MASKS : GARBLE;
				end
			end
			GARBLE: begin
				if (need0 || need1) begin
					if (credit_ok) begin
						take0 = need0;
						take1 = need1;
						labels.wr_en0 = need0;
						labels.wr_en1 = need1;
						tag = need0 ? (need1 ? TAG_INPUT_BOTH : TAG_INPUT0) : TAG_INPUT1;
						index0 = need0 ? gate.in0 : '1;
						index1 = need1 ? gate.in1 : '1;
						data0 = need0 ? label0 : '0;
						data1 = need1 ? label1 : '0;
					end
				end else begin
					// both operands ready, store the output label
					gate_done = 1'b1;
					labels.wr_en0 = 1'b1;
					labels.wr_addr0 = out_wire;
					labels.wr_label0 = result;
					if (last_gate) begin
						next_state = MASKS;
					end
				end
			end
			MASKS: begin
				if (credit_ok) begin
					tag = TAG_MASKS;
					data0 = mask[LABEL_W-1:0];
					data1 = mask[MAX_OUTPUTS-1:LABEL_W];
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			gate_cnt <= '0;
			out_cnt <= '0;
		end else begin
			state <= next_state;
			if (start_run) begin
				gate_cnt <= '0;
				out_cnt <= '0;
			end else if (gate_done) begin
				gate_cnt <= gate_cnt + GATE_W'(1);
				if (gate.is_output) begin
					out_cnt <= out_cnt + 1'b1;
				end
			end
		end
	end

	// one credit per message, one back per return pulse
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits <= CREDIT_W'(CREDITS);
		end else begin
			credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(tag != TAG_NONE);
		end
	end

	// first output lands in mask bit 0
	always_ff @(posedge clk) begin
		if (start_run) begin
			mask <= '0;
		end else if (gate_done && gate.is_output) begin
			mask[out_cnt] <= result[0];
		end
		if (state == KEYS && credit_ok) begin
			r_offset <= r_next;
		end
	end

endmodule

//--- design/garbler_top.sv
module garbler_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic nl_wr,
	input logic nl_is_output,
	input logic credit_return,
	input logic [gc_pkg::GATE_W-1:0] nl_index,
	input gc_pkg::gate_op_t nl_op,
	input gc_pkg::wire_id_t nl_in0,
	input gc_pkg::wire_id_t nl_in1,
	input gc_pkg::wire_id_t n_inputs,
	input logic [gc_pkg::GATE_W-1:0] n_gates,
	output logic busy,
	output gc_pkg::msg_tag_t tag,
	output gc_pkg::wire_id_t index0,
	output gc_pkg::wire_id_t index1,
	output gc_pkg::label_t data0,
	output gc_pkg::label_t data1
);
	import gc_pkg::*;

	gate_t nl_gate;
	gate_t cur_gate;
	logic [GATE_W-1:0] gate_index;
	logic take0;
	logic take1;
	label_t label0;
	label_t label1;

	label_port_if labels_if ();

	assign nl_gate = '{op: nl_op, in0: nl_in0, in1: nl_in1, is_output: nl_is_output};

	label_gen u_label_gen (
		.clk(clk),
		.rst(rst),
		.take0(take0),
		.take1(take1),
		.label0(label0),
		.label1(label1)
	);

	netlist_store u_netlist_store (
		.clk(clk),
		.wr(nl_wr),
		.wr_index(nl_index),
		.wr_gate(nl_gate),
		.rd_index(gate_index),
		.rd_gate(cur_gate)
	);

	wire_label_store u_wire_label_store (
		.clk(clk),
		.rst(rst),
		.port(labels_if.slave)
	);

	garble_sequencer u_garble_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.credit_return(credit_return),
		.n_inputs(n_inputs),
		.n_gates(n_gates),
		.gate(cur_gate),
		.label0(label0),
		.label1(label1),
		.gate_index(gate_index),
		.take0(take0),
		.take1(take1),
		.busy(busy),
		.tag(tag),
		.index0(index0),
		.index1(index1),
		.data0(data0),
		.data1(data1),
		.labels(labels_if.master)
	);

endmodule

//--- design/gc_pkg.sv
package gc_pkg;

	// label and index widths
	localparam int LABEL_W = 128;
	localparam int WIRE_W = 10;
	localparam int GATE_W = 9;

	// output masks fill the two data words of one message
	localparam int MAX_OUTPUTS = 2 * LABEL_W;

	// message credits held after reset
	localparam int CREDITS = 4;
	localparam int CREDIT_W = $clog2(CREDITS + 1);

	typedef logic [LABEL_W-1:0] label_t;
	typedef logic [WIRE_W-1:0] wire_id_t;

	// wire numbering
	// constants first, then circuit inputs, then one wire per gate
	localparam wire_id_t WIRE_CONST0 = 10'd0;
	localparam wire_id_t WIRE_CONST1 = 10'd1;
	localparam wire_id_t WIRE_INPUT_BASE = 10'd2;

	// xorshift lane seeds, must be nonzero
	localparam label_t SEED_A = 128'h3c6e_f372_fe94_f82b_a54f_f53a_5f1d_36f1;
	localparam label_t SEED_B = 128'h510e_527f_ade6_82d1_9b05_688c_2b3e_6c1f;

	typedef enum logic [1:0] {
		GATE_XOR = 2'b00,
		GATE_XNOR = 2'b01,
		GATE_NOT = 2'b10
	} gate_op_t;

	typedef struct packed {
		gate_op_t op;
		wire_id_t in0;
		wire_id_t in1;
		logic is_output;
	} gate_t;

	// none means no message in this cycle
	typedef enum logic [2:0] {
		TAG_NONE = 3'b000,
		TAG_KEYS = 3'b001,
		TAG_MASKS = 3'b011,
		TAG_INPUT0 = 3'b101,
		TAG_INPUT1 = 3'b110,
		TAG_INPUT_BOTH = 3'b111
	} msg_tag_t;

endpackage

//--- design/label_gen.sv
module label_gen (
	input logic clk,
	input logic rst,
	input logic take0,
	input logic take1,
	output gc_pkg::label_t label0,
	output gc_pkg::label_t label1
);
	import gc_pkg::*;

	label_t lane0;
	label_t lane1;

	// xorshift128 over four 32-bit words, period 2^128-1
	function automatic label_t xorshift_step(input label_t s);
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] z;
		logic [31:0] w;
		logic [31:0] t;
		{w, z, y, x} = s;
		t = x ^ (x << 11);
		x = y;
		y = z;
		z = w;
		w = w ^ (w >> 19) ^ t ^ (t >> 8);
		return {w, z, y, x};
	endfunction

	// a lane only moves when its label is consumed
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane0 <= SEED_A;
			lane1 <= SEED_B;
		end else begin
			if (take0) begin
				lane0 <= xorshift_step(lane0);
			end
			if (take1) begin
				lane1 <= xorshift_step(lane1);
			end
		end
	end

	assign label0 = lane0;
	assign label1 = lane1;

endmodule

//--- design/label_port_if.sv
interface label_port_if;
	import gc_pkg::*;

	// two combinational read ports
	wire_id_t rd_addr0;
	wire_id_t rd_addr1;
	label_t rd_label0;
	label_t rd_label1;
	logic rd_defined0;
	logic rd_defined1;

	// two write ports, effective at the next edge
	logic wr_en0;
	logic wr_en1;
	wire_id_t wr_addr0;
	wire_id_t wr_addr1;
	label_t wr_label0;
	label_t wr_label1;

	// drops every defined flag in one cycle
	logic clear;

	modport master (
		output rd_addr0, rd_addr1, wr_en0, wr_en1, wr_addr0, wr_addr1,
		output wr_label0, wr_label1, clear,
		input rd_label0, rd_label1, rd_defined0, rd_defined1
	);

	modport slave (
		input rd_addr0, rd_addr1, wr_en0, wr_en1, wr_addr0, wr_addr1,
		input wr_label0, wr_label1, clear,
		output rd_label0, rd_label1, rd_defined0, rd_defined1
	);

endinterface

//--- design/netlist_store.sv
module netlist_store (
	input logic clk,
	input logic wr,
	input logic [gc_pkg::GATE_W-1:0] wr_index,
	input gc_pkg::gate_t wr_gate,
	input logic [gc_pkg::GATE_W-1:0] rd_index,
	output gc_pkg::gate_t rd_gate
);
	import gc_pkg::*;

	localparam int DEPTH = 2 ** GATE_W;

	// one entry per gate, in topological order
	gate_t mem [DEPTH];

	// host loads the netlist before start
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_index] <= wr_gate;
		end
	end

	// asynchronous read, the sequencer evaluates in the same cycle
	assign rd_gate = mem[rd_index];

endmodule

//--- design/wire_label_store.sv
module wire_label_store (
	input logic clk,
	input logic rst,
	label_port_if.slave port
);
	import gc_pkg::*;

	localparam int DEPTH = 2 ** WIRE_W;

	label_t labels [DEPTH];
	logic [DEPTH-1:0] defined;

	// port 1 is assigned last so it wins on an address clash
	always_ff @(posedge clk) begin
		if (port.wr_en0) begin
			labels[port.wr_addr0] <= port.wr_label0;
		end
		if (port.wr_en1) begin
			labels[port.wr_addr1] <= port.wr_label1;
		end
	end

	// flags mark which wires hold a valid label in this run
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			defined <= '0;
		end else if (port.clear) begin
			defined <= '0;
		end else begin
			if (port.wr_en0) begin
				defined[port.wr_addr0] <= 1'b1;
			end
			if (port.wr_en1) begin
				defined[port.wr_addr1] <= 1'b1;
			end
		end
	end

	assign port.rd_label0 = labels[port.rd_addr0];
	assign port.rd_label1 = labels[port.rd_addr1];
	assign port.rd_defined0 = defined[port.rd_addr0];
	assign port.rd_defined1 = defined[port.rd_addr1];

endmodule

//--- dv/garbler_props.sv
module garbler_props (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic in_idle,
	input gc_pkg::msg_tag_t tag,
	input gc_pkg::label_t data0,
	input gc_pkg::label_t r_offset,
	input logic [gc_pkg::CREDIT_W-1:0] credits
);
	timeunit 1ns;
	timeprecision 1ps;
	import gc_pkg::*;

	// every message spends a credit, so none may leave at zero
	assert property (@(posedge clk) disable iff (rst) (credits == '0) |-> (tag == TAG_NONE))
		else $error("message sent while no credit was held");

	// a return pulse on a full counter would push it past the limit
	assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_W'(CREDITS))
		else $error("credit count above its reset value");

	// the offset kept for evaluation is the one sent and has its point-and-permute bit set
	assert property (@(posedge clk) disable iff (rst)
			(tag == TAG_KEYS) |=> (r_offset == $past(data0)) && r_offset[0])
		else $error("offset held after the keys message differs from the one sent");

	// busy stays low in IDLE until a start raises it at the next edge
	assert property (@(posedge clk) disable iff (rst) in_idle |=> (busy == $past(start)))
		else $error("busy does not follow start out of IDLE");

endmodule

bind garble_sequencer garbler_props u_props (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.in_idle(state == IDLE),
	.tag(tag),
	.data0(data0),
	.r_offset(r_offset),
	.credits(credits)
);

//--- dv/garbler_tb.sv
module garbler_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import gc_pkg::*;

	localparam int WAIT_LIMIT = 5000;

	logic clk;
	logic rst;
	logic start;
	logic nl_wr;
	logic nl_is_output;
	logic credit_return = 1'b0;
	logic [GATE_W-1:0] nl_index;
	gate_op_t nl_op;
	wire_id_t nl_in0;
	wire_id_t nl_in1;
	wire_id_t n_inputs;
	logic [GATE_W-1:0] n_gates;
	logic busy;
	msg_tag_t tag;
	wire_id_t index0;
	wire_id_t index1;
	label_t data0;
	label_t data1;

	// netlist as loaded, and wire labels as the model sees them
	gate_t gates [int];
	label_t model_labels [int];

	// every message of the current run
	msg_tag_t msg_tags [$];
	wire_id_t msg_idx0 [$];
	wire_id_t msg_idx1 [$];
	label_t msg_d0 [$];
	label_t msg_d1 [$];

	int owed;
	int outstanding;
	int return_pct;

	garbler_top DUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.nl_wr(nl_wr),
		.nl_is_output(nl_is_output),
		.credit_return(credit_return),
		.nl_index(nl_index),
		.nl_op(nl_op),
		.nl_in0(nl_in0),
		.nl_in1(nl_in1),
		.n_inputs(n_inputs),
		.n_gates(n_gates),
		.busy(busy),
		.tag(tag),
		.index0(index0),
		.index1(index1),
		.data0(data0),
		.data1(data1)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic report_error(input string what);
		$display("%0t: %s", $time, what);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [255:0] actual,
			input logic [255:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
			report_error("value mismatch");
		end
	endtask

	// monitor samples mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!rst) begin
			if (tag != TAG_NONE) begin
				msg_tags.push_back(tag);
				msg_idx0.push_back(index0);
				msg_idx1.push_back(index1);
				msg_d0.push_back(data0);
				msg_d1.push_back(data1);
				outstanding++;
				owed++;
			end
			if (credit_return) begin
				outstanding--;
			end
			if (outstanding > CREDITS) begin
				check_value("outstanding messages", 256'(outstanding), 256'(CREDITS));
			end
		end
	end

	// host side hands credits back after a random delay
	always @(posedge clk) begin
		if (rst) begin
			credit_return <= 1'b0;
		end else if (owed > 0 && int'($urandom_range(99)) < return_pct) begin
			credit_return <= 1'b1;
			owed--;
		end else begin
			credit_return <= 1'b0;
		end
	end

	task automatic wait_busy(input logic level);
		int cycles;
		cycles = 0;
		while (busy !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				report_error($sformatf("timed out waiting for busy to become %0d", level));
			end
		end
	endtask

	task automatic load_gate(input int g, input gate_op_t op, input int a, input int b,
			input logic is_out);
		gates[g] = '{op: op, in0: wire_id_t'(a), in1: wire_id_t'(b), is_output: is_out};
		@(posedge clk);
		nl_wr <= 1'b1;
		nl_index <= GATE_W'(g);
		nl_op <= op;
		nl_in0 <= wire_id_t'(a);
		nl_in1 <= wire_id_t'(b);
		nl_is_output <= is_out;
	endtask

	task automatic record_input(input int w, input label_t lbl, input int ni);
		check_value($sformatf("input index %0d in range", w),
			256'(w >= 2 && w <= ni + 1), 256'd1);
		check_value($sformatf("input %0d sent once", w),
			256'(model_labels.exists(w)), 256'd0);
		model_labels[w] = lbl;
	endtask

	task automatic check_messages(input int ni, input int ng);
		bit used [int];
		logic [MAX_OUTPUTS-1:0] mask;
		label_t r;
		label_t res;
		gate_t gt;
		int n;
		int outs;
		n = msg_tags.size();
		check_value("message count at least 3", 256'(n >= 3), 256'd1);
		check_value("first tag", 256'(msg_tags[0]), 256'(TAG_KEYS));
		check_value("keys data0 bit 0", 256'(msg_d0[0][0]), 256'd1);
		check_value("keys index0", 256'(msg_idx0[0]), 256'(10'h3ff));
		r = msg_d0[0];
		check_value("second tag", 256'(msg_tags[1]), 256'(TAG_INPUT_BOTH));
		check_value("constants index0", 256'(msg_idx0[1]), 256'd0);
		check_value("constants index1", 256'(msg_idx1[1]), 256'd1);
		model_labels.delete();
		model_labels[0] = msg_d0[1];
		model_labels[1] = msg_d1[1];
		for (int i = 2; i < n - 1; i++) begin
			if (msg_tags[i] == TAG_INPUT0 || msg_tags[i] == TAG_INPUT_BOTH) begin
				record_input(int'(msg_idx0[i]), msg_d0[i], ni);
			end
			if (msg_tags[i] == TAG_INPUT1 || msg_tags[i] == TAG_INPUT_BOTH) begin
				record_input(int'(msg_idx1[i]), msg_d1[i], ni);
			end
			if (msg_tags[i] != TAG_INPUT0 && msg_tags[i] != TAG_INPUT1
					&& msg_tags[i] != TAG_INPUT_BOTH) begin
				report_error($sformatf("unexpected tag %0d in message %0d", msg_tags[i], i));
			end
		end
		check_value("last tag", 256'(msg_tags[n-1]), 256'(TAG_MASKS));
		// an input is sent exactly when some gate reads it; NOT ignores in1
		for (int g = 0; g < ng; g++) begin
			used[int'(gates[g].in0)] = 1'b1;
			if (gates[g].op != GATE_NOT) begin
				used[int'(gates[g].in1)] = 1'b1;
			end
		end
		for (int w = 2; w < ni + 2; w++) begin
			check_value($sformatf("input %0d sent", w),
				256'(model_labels.exists(w)), 256'(used.exists(w)));
		end
		mask = '0;
		outs = 0;
		for (int g = 0; g < ng; g++) begin
			gt = gates[g];
			if (!model_labels.exists(int'(gt.in0))
					|| (gt.op != GATE_NOT && !model_labels.exists(int'(gt.in1)))) begin
				report_error($sformatf("gate %0d reads a wire with no label", g));
			end
			case (gt.op)
				GATE_XNOR: res = model_labels[int'(gt.in0)] ^ model_labels[int'(gt.in1)] ^ r;
				GATE_NOT: res = model_labels[int'(gt.in0)] ^ r;
				default: res = model_labels[int'(gt.in0)] ^ model_labels[int'(gt.in1)];
			endcase
			model_labels[ni + 2 + g] = res;
			if (gt.is_output) begin
				mask = mask | (MAX_OUTPUTS'(res[0]) << outs);
				outs++;
			end
		end
		check_value("masks data0", 256'(msg_d0[n-1]), 256'(mask[LABEL_W-1:0]));
		check_value("masks data1", 256'(msg_d1[n-1]), 256'(mask[MAX_OUTPUTS-1:LABEL_W]));
		check_value("masks index1", 256'(msg_idx1[n-1]), 256'(10'h3ff));
	endtask

	task automatic run_garbler(input int ni, input int ng);
		msg_tags.delete();
		msg_idx0.delete();
		msg_idx1.delete();
		msg_d0.delete();
		msg_d1.delete();
		@(posedge clk);
		nl_wr <= 1'b0;
		n_inputs <= wire_id_t'(ni);
		n_gates <= GATE_W'(ng);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_busy(1'b1);
		wait_busy(1'b0);
		check_value("tag after run", 256'(tag), 256'(TAG_NONE));
		check_messages(ni, ng);
	endtask

	task automatic test_reset_state();
		repeat (3) begin
			@(negedge clk);
			check_value("tag after reset", 256'(tag), 256'(TAG_NONE));
			check_value("busy after reset", 256'(busy), 256'd0);
		end
	endtask

	// input 7 is only the unused in1 of a NOT, so it must never be sent
	task automatic test_fixed_netlist();
		load_gate(0, GATE_XOR, 2, 3, 1'b0);
		load_gate(1, GATE_XNOR, 4, 8, 1'b1);
		load_gate(2, GATE_NOT, 5, 7, 1'b1);
		load_gate(3, GATE_XOR, 9, 10, 1'b1);
		load_gate(4, GATE_XNOR, 0, 1, 1'b1);
		load_gate(5, GATE_NOT, 1, 0, 1'b1);
		load_gate(6, GATE_XOR, 2, 2, 1'b1);
		load_gate(7, GATE_XOR, 6, 6, 1'b1);
		load_gate(8, GATE_XNOR, 11, 12, 1'b1);
		run_garbler(6, 9);
	endtask

	task automatic test_random_netlists(input int runs);
		int ni;
		int ng;
		int top;
		return_pct = 30;
		for (int k = 0; k < runs; k++) begin
			ni = 1 + int'($urandom_range(11));
			ng = 1 + int'($urandom_range(39));
			for (int g = 0; g < ng; g++) begin
				// any wire already driven may feed gate g
				top = ni + 1 + g;
				load_gate(g, gate_op_t'($urandom_range(2)), int'($urandom_range(top)),
					int'($urandom_range(top)), 1'($urandom_range(1)));
			end
			run_garbler(ni, ng);
		end
		return_pct = 100;
	endtask

	initial begin
		void'($urandom(32'h162798e5));
		owed = 0;
		outstanding = 0;
		return_pct = 100;
		rst = 1'b1;
		start = 1'b0;
		nl_wr = 1'b0;
		nl_is_output = 1'b0;
		nl_index = '0;
		nl_op = GATE_XOR;
		nl_in0 = '0;
		nl_in1 = '0;
		n_inputs = '0;
		n_gates = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		test_reset_state();
		test_fixed_netlist();
		test_random_netlists(20);
		$display("Test OK");
		$finish;
	end

endmodule

//--- vlog.f
design/gc_pkg.sv
design/label_port_if.sv
design/label_gen.sv
design/netlist_store.sv
design/wire_label_store.sv
design/garble_sequencer.sv
design/garbler_top.sv
dv/garbler_props.sv
dv/garbler_tb.sv
